// File: tests/route_stim.txt
# kind run pattern cycles mode digit3 leftLeds midLeds
# D holds the inputs for cycles edges, W waits up to cycles edges for mode
D 1 000 1 1 11 00001 000000
D 1 010 1 2 3 00010 111111
D 1 010 7 2 3 00010 000000
D 1 010 1 2 2 00010 111111
D 1 010 8 2 1 00010 111111
D 1 010 7 2 1 00010 000000
D 1 010 1 3 1 01000 001100
D 1 001 1 9 1 00000 000000
D 1 100 1 8 1 00000 000000
D 1 010 1 3 1 01000 001100
D 1 111 1 4 0 00100 000000
D 1 010 1 4 1 00100 000000
D 1 111 1 3 0 01000 001100
D 1 010 1 3 1 01000 001100
D 1 111 1 4 0 00100 000000
D 1 101 1 30 13 11100 111111
D 1 010 15 30 13 11100 111111
D 1 010 1 5 0 10000 110000
D 1 010 1 5 1 10000 110000
D 1 111 1 30 0 11100 111111
W 1 010 20 3 0 01000 001100
D 1 000 1 30 13 11100 111111
W 1 000 20 7 0 01010 111111
D 1 000 4 7 0 01010 000000
D 1 000 4 7 0 01010 111111
D 1 111 1 30 13 11100 111111
W 1 010 20 5 0 10000 110000
D 1 101 1 30 15 11100 111111
W 1 010 20 6 0 00100 000011
D 1 111 3 6 0 00100 000011
D 1 101 1 31 15 11111 000000
D 0 000 1 0 14 00000 000000

// File: sources.f
+incdir+include
design/carPkg.sv
design/routeFsm.sv
design/phaseTimer.sv
design/statusLeds.sv
design/digitCodes.sv
design/lineFollowerTop.sv
tests/lineFollowerTb.sv

// File: tests/lineFollowerTb.sv
module lineFollowerTb;

    logic                 clk;
    logic                 rst;
    logic                 runEnable;
    carPkg::roadPattern_t roadPattern;
    logic [15:0]          led;
    carPkg::digitCodes_t  digits;
    carPkg::routeState_t  driveMode;
    int                   stepNo;

    lineFollowerTop i_lineFollowerTop (
        .clk         (clk),
        .rst         (rst),
        .runEnable   (runEnable),
        .roadPattern (roadPattern),
        .led         (led),
        .digits      (digits),
        .driveMode   (driveMode)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopOnFailure();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("Error at time %0t, step %0d: %s expected %0d, got %0d",
                     $time, stepNo, name, expected, actual);
            stopOnFailure();
        end
    endtask

    // first three panel digits for each drive mode
    function automatic logic [11:0] expectedLeadDigits(input int mode);
        case (mode)
            0: return {4'd1, 4'd12, 4'd13};
            1, 2: return {4'd11, 4'd11, 4'd11};
            3, 8, 9: return {4'd10, 4'd2, 4'd11};
            4: return {4'd10, 4'd1, 4'd11};
            5: return {4'd10, 4'd3, 4'd11};
            6: return {4'd10, 4'd4, 4'd11};
            7, 30: return {4'd0, 4'd0, 4'd0};
            default: return {4'd15, 4'd15, 4'd15};
        endcase
    endfunction

    task automatic checkLeadDigits(input int mode);
        logic [11:0] lead;
        lead = expectedLeadDigits(mode);
        checkValue("digits.digit0", lead[11:8], digits.digit0);
        checkValue("digits.digit1", lead[7:4], digits.digit1);
        checkValue("digits.digit2", lead[3:0], digits.digit2);
    endtask

    // outputs are sampled 2 units after the edge, then new inputs go out
    task automatic holdCycles(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic waitForMode(input int expMode, input int limit);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (driveMode != expMode && waited < limit);
        assert (driveMode == expMode)
        else begin
            $display("Timeout in step %0d: driveMode did not reach %0d within %0d cycles",
                     stepNo, expMode, limit);
            stopOnFailure();
        end
    endtask

    initial begin
        int         fd;
        int         fields;
        int         run;
        int         cycles;
        int         expMode;
        int         expDigit;
        string      line;
        logic [7:0] kind;
        logic [2:0] pattern;
        logic [4:0] expLeft;
        logic [5:0] expMid;

        stepNo = 0;
        rst = 1'b1;
        runEnable = 1'b0;
        roadPattern = carPkg::ROAD_LOST;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // state straight out of reset, idle panel reads 1 12 13 14
        checkValue("driveMode", 0, driveMode);
        checkValue("led", 0, led);
        checkLeadDigits(0);
        checkValue("digits.digit3", 14, digits.digit3);

        fd = $fopen("tests/route_stim.txt", "r");
        assert (fd != 0)
        else begin
            $display("Could not open the stimulus file tests/route_stim.txt");
            stopOnFailure();
        end

        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            fields = $sscanf(line, "%c %d %b %d %d %d %b %b", kind, run, pattern, cycles,
                             expMode, expDigit, expLeft, expMid);
            // comment and blank lines fall through here
            if (fields == 8) begin
                stepNo++;
                runEnable = run[0];
                roadPattern = carPkg::roadPattern_t'(pattern);
                if (kind == "W") begin
                    waitForMode(expMode, cycles);
                end else begin
                    holdCycles(cycles);
                end
                checkValue("driveMode", expMode, driveMode);
                checkValue("digits.digit3", expDigit, digits.digit3);
                checkLeadDigits(expMode);
                checkValue("led[15:11]", expLeft, led[15:11]);
                checkValue("led[10]", 0, led[10]);
                checkValue("led[9:4]", expMid, led[9:4]);
                checkValue("led[3]", 0, led[3]);
                // low LEDs mirror the sensor pattern
                checkValue("led[2:0]", pattern, led[2:0]);
            end
        end
        $fclose(fd);

        assert (stepNo > 0)
        else begin
            $display("No steps were read from the stimulus file");
            stopOnFailure();
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: design/lineFollowerTop.sv
module lineFollowerTop (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 runEnable,
    input  carPkg::roadPattern_t roadPattern,
    output logic [15:0]          led,
    output carPkg::digitCodes_t  digits,
    output carPkg::routeState_t  driveMode
);
    carPkg::routeStatus_t route;
    carPkg::timerStatus_t timer;

    routeFsm i_routeFsm (
        .clk         (clk),
        .rst         (rst),
        .runEnable   (runEnable),
        .roadPattern (roadPattern),
        .timer       (timer),
        .route       (route)
    );

    phaseTimer i_phaseTimer (
        .clk   (clk),
        .rst   (rst),
        .route (route),
        .timer (timer)
    );

    statusLeds i_statusLeds (
        .clk         (clk),
        .rst         (rst),
        .route       (route),
        .timer       (timer),
        .roadPattern (roadPattern),
        .led         (led)
    );

    digitCodes i_digitCodes (
        .route  (route),
        .timer  (timer),
        .digits (digits)
    );

    // motor mode is the route state itself
    assign driveMode = route.state;

endmodule

// File: design/digitCodes.sv
module digitCodes (
    input  carPkg::routeStatus_t route,
    input  carPkg::timerStatus_t timer,
    output carPkg::digitCodes_t  digits
);
    logic [3:0] cpCode;

    assign cpCode = {3'b000, route.checkpointSet};

    always_comb begin
        case (route.state)
            carPkg::IDLE: digits = '{4'd1, 4'd12, 4'd13, 4'd14};
            carPkg::START: digits = '{4'd11, 4'd11, 4'd11, 4'd11};
            carPkg::COUNT: digits = '{4'd11, 4'd11, 4'd11, {2'b00, timer.countDigit}};
            carPkg::STRAIGHT, carPkg::LITTLE_LEFT, carPkg::LITTLE_RIGHT:
                digits = '{4'd10, 4'd2, 4'd11, cpCode};
            carPkg::CHOOSE: digits = '{4'd10, 4'd1, 4'd11, cpCode};
            carPkg::LEFT: digits = '{4'd10, 4'd3, 4'd11, cpCode};
            carPkg::RIGHT: digits = '{4'd10, 4'd4, 4'd11, cpCode};
            carPkg::BACK: digits = '{4'd0, 4'd0, 4'd0, 4'd0};
            carPkg::STOP: begin
                digits = '{4'd0, 4'd0, 4'd0, 4'd15};
                // last digit tells where the car goes after the pause
                case (route.resumeTarget)
                    carPkg::BACK: digits.digit3 = 4'd13;
                    carPkg::LEFT: digits.digit3 = 4'd13;
                    carPkg::RIGHT: digits.digit3 = 4'd15;
                    carPkg::STRAIGHT: digits.digit3 = 4'd0;
                    default: digits.digit3 = 4'd15;
                endcase
            end
            default: digits = '{4'd15, 4'd15, 4'd15, 4'd15};
        endcase
    end

endmodule

// File: design/statusLeds.sv
`include "car_cfg.svh"

module statusLeds (
    input  logic                 clk,
    input  logic                 rst,
    input  carPkg::routeStatus_t route,
    input  carPkg::timerStatus_t timer,
    input  carPkg::roadPattern_t roadPattern,
    output logic [15:0]          led
);
    localparam logic [`CAR_DIV_WIDTH-1:0] LAMP_LAST = `CAR_LAMP_CYCLES - 1;

    logic [`CAR_DIV_WIDTH-1:0] lampCnt;
    logic [2:0]                chooseLamp;
    logic [4:0]                stateBits;
    logic [5:0]                motionBits;

    // rotating lamp while waiting in CHOOSE
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lampCnt <= '0;
            chooseLamp <= 3'b001;
        end else if (route.state != carPkg::CHOOSE) begin
            lampCnt <= '0;
            chooseLamp <= 3'b001;
        end else if (lampCnt == LAMP_LAST) begin
            lampCnt <= '0;
            chooseLamp <= {chooseLamp[1:0], chooseLamp[2]};
        end else begin
            lampCnt <= lampCnt + 1'b1;
        end
    end

    // left group, one pattern per state
    always_comb begin
        case (route.state)
            carPkg::START: stateBits = 5'b00001;
            carPkg::COUNT: stateBits = 5'b00010;
            carPkg::STRAIGHT: stateBits = 5'b01000;
            carPkg::CHOOSE: stateBits = {chooseLamp, 2'b00};
            carPkg::LEFT: stateBits = 5'b10000;
            carPkg::RIGHT: stateBits = 5'b00100;
            carPkg::STOP: stateBits = 5'b11100;
            carPkg::BACK: stateBits = 5'b01010;
            carPkg::ERROR: stateBits = 5'b11111;
            default: stateBits = 5'b00000;
        endcase
    end

    // middle group shows the heading
    always_comb begin
        case (route.state)
            carPkg::COUNT, carPkg::BACK: motionBits = timer.flash ? 6'b000000 : 6'b111111;
            carPkg::STRAIGHT: motionBits = 6'b001100;
            carPkg::RIGHT: motionBits = 6'b000011;
            carPkg::LEFT: motionBits = 6'b110000;
            carPkg::STOP: motionBits = 6'b111111;
            default: motionBits = 6'b000000;
        endcase
    end

    // raw sensor bits sit in the low three LEDs
    assign led = {stateBits, 1'b0, motionBits, 1'b0, roadPattern};

endmodule

// File: design/phaseTimer.sv
`include "car_cfg.svh"

module phaseTimer (
    input  logic                 clk,
    input  logic                 rst,
    input  carPkg::routeStatus_t route,
    output carPkg::timerStatus_t timer
);
    localparam logic [`CAR_DIV_WIDTH-1:0] TICK_LAST = `CAR_TICK_CYCLES - 1;
    localparam logic [`CAR_DIV_WIDTH-1:0] FLASH_LAST = `CAR_FLASH_CYCLES - 1;
    localparam logic [`CAR_TICK_WIDTH-1:0] COUNT_TICKS = `CAR_COUNT_TICKS;
    localparam logic [`CAR_TICK_WIDTH-1:0] COUNT_LAST = `CAR_COUNT_TICKS - 1;
    localparam logic [`CAR_TICK_WIDTH-1:0] STOP_LAST = `CAR_STOP_TICKS - 1;

    carPkg::routeState_t        lastState;
    logic [`CAR_DIV_WIDTH-1:0]  cycleCnt;
    logic [`CAR_DIV_WIDTH-1:0]  cycleNow;
    logic [`CAR_TICK_WIDTH-1:0] tickCnt;
    logic [`CAR_TICK_WIDTH-1:0] tickNow;
    logic [`CAR_TICK_WIDTH-1:0] remaining;
    logic [`CAR_DIV_WIDTH-1:0]  flashCnt;
    logic [`CAR_DIV_WIDTH-1:0]  flashNow;
    logic                       flashReg;
    logic                       flashLevel;
    logic                       fresh;
    logic                       tickRun;
    logic                       flashRun;
    logic                       tick;

    assign tickRun = route.state inside {carPkg::COUNT, carPkg::STOP, carPkg::BACK};
    assign flashRun = route.state inside {carPkg::COUNT, carPkg::BACK};

    // first cycle of a new state sees all counters at zero, so BACK into STOP restarts
    assign fresh = route.state != lastState;
    assign cycleNow = fresh ? '0 : cycleCnt;
    assign tickNow = fresh ? '0 : tickCnt;
    assign flashNow = fresh ? '0 : flashCnt;
    assign flashLevel = fresh ? 1'b0 : flashReg;

    assign tick = tickRun && (cycleNow == TICK_LAST);
    assign remaining = COUNT_TICKS - tickNow;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lastState <= carPkg::IDLE;
            cycleCnt <= '0;
            tickCnt <= '0;
            flashCnt <= '0;
            flashReg <= 1'b0;
        end else begin
            lastState <= route.state;
            if (tickRun) begin
                cycleCnt <= tick ? '0 : cycleNow + 1'b1;
                tickCnt <= tick ? tickNow + 1'b1 : tickNow;
            end else begin
                cycleCnt <= '0;
                tickCnt <= '0;
            end
            if (!flashRun) begin
                flashCnt <= '0;
                flashReg <= 1'b0;
            end else if (flashNow == FLASH_LAST) begin
                flashCnt <= '0;
                flashReg <= ~flashLevel;
            end else begin
                flashCnt <= flashNow + 1'b1;
                flashReg <= flashLevel;
            end
        end
    end

    always_comb begin
        timer.countDone = (route.state == carPkg::COUNT) && tick && (tickNow == COUNT_LAST);
        timer.countDigit = (route.state == carPkg::COUNT) ? remaining[1:0] : 2'd0;
        timer.resumeGo = (route.state == carPkg::STOP) && tick && (tickNow == STOP_LAST);
        timer.flash = flashRun && flashLevel;
    end

    // remaining count must fit the two-bit digit for the whole countdown
    countDigitRange: assert property (@(posedge clk) disable iff (rst)
        (route.state == carPkg::COUNT) |-> (remaining >= 1 && remaining <= 3))
        else $error("countdown digit out of range: %0d", remaining);

endmodule

// File: design/routeFsm.sv
`include "car_cfg.svh"

module routeFsm (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 runEnable,
    input  carPkg::roadPattern_t roadPattern,
    input  carPkg::timerStatus_t timer,
    output carPkg::routeStatus_t route
);
    // checkpoint flag slots
    localparam int CP_STRAIGHT = 0;
    localparam int CP_CHOOSE = 1;
    localparam int CP_LEFT = 2;
    localparam int CP_RIGHT = 3;

    localparam int CONFIRM_W = $clog2(`CAR_RIGHT_CONFIRM + 1);
    localparam logic [CONFIRM_W-1:0] RIGHT_CONFIRM = `CAR_RIGHT_CONFIRM;

    carPkg::routeState_t  state;
    carPkg::routeState_t  nextState;
    carPkg::routeState_t  resumeTarget;
    carPkg::routeState_t  resumeNext;
    logic [3:0]           checkpoint;
    logic [3:0]           cpRegion;
    logic [CONFIRM_W-1:0] rightCnt;
    logic                 rightDone;
    logic                 crossSeen;
    logic                 forkSeen;

    assign crossSeen = roadPattern == carPkg::CROSS_ROAD;
    assign forkSeen = roadPattern == carPkg::FORK_ROAD;
    assign rightDone = rightCnt == RIGHT_CONFIRM;

    // which checkpoint belongs to the current state
    always_comb begin
        cpRegion = '0;
        cpRegion[CP_STRAIGHT] = state inside {carPkg::STRAIGHT, carPkg::LITTLE_LEFT,
                                              carPkg::LITTLE_RIGHT};
        cpRegion[CP_CHOOSE] = state == carPkg::CHOOSE;
        cpRegion[CP_LEFT] = state == carPkg::LEFT;
        cpRegion[CP_RIGHT] = state == carPkg::RIGHT;
    end

    always_comb begin
        nextState = state;
        resumeNext = resumeTarget;
        case (state)
            carPkg::IDLE:
                if (runEnable) nextState = carPkg::START;
            carPkg::START:
                if (roadPattern == carPkg::STRAIGHT_ROAD) nextState = carPkg::COUNT;
            carPkg::COUNT:
                if (timer.countDone) nextState = carPkg::STRAIGHT;
            carPkg::STRAIGHT, carPkg::LITTLE_LEFT, carPkg::LITTLE_RIGHT: begin
                case (roadPattern)
                    carPkg::LITTLE_RIGHT_ROAD: nextState = carPkg::LITTLE_RIGHT;
                    carPkg::LITTLE_LEFT_ROAD: nextState = carPkg::LITTLE_LEFT;
                    carPkg::ROAD_LOST: begin
                        nextState = carPkg::STOP;
                        resumeNext = carPkg::BACK;
                    end
                    carPkg::CROSS_ROAD:
                        if (checkpoint[CP_STRAIGHT]) nextState = carPkg::CHOOSE;
                    default: nextState = carPkg::STRAIGHT;
                endcase
            end
            carPkg::CHOOSE: begin
                if (forkSeen) begin
                    nextState = carPkg::STOP;
                    resumeNext = carPkg::LEFT;
                end else if (crossSeen && checkpoint[CP_CHOOSE]) begin
                    nextState = carPkg::STRAIGHT;
                end
            end
            carPkg::LEFT: begin
                if (forkSeen) begin
                    nextState = carPkg::STOP;
                    resumeNext = carPkg::RIGHT;
                end else if (crossSeen && checkpoint[CP_LEFT]) begin
                    nextState = carPkg::STOP;
                    resumeNext = carPkg::STRAIGHT;
                end
            end
            carPkg::RIGHT: begin
                // only a confirmed turn may leave RIGHT
                if (crossSeen && checkpoint[CP_RIGHT] && rightDone) begin
                    nextState = carPkg::STOP;
                    resumeNext = carPkg::STRAIGHT;
                end else if (forkSeen && rightDone) begin
                    nextState = carPkg::ERROR;
                end
            end
            carPkg::BACK: begin
                if (crossSeen) begin
                    nextState = carPkg::STOP;
                    resumeNext = carPkg::LEFT;
                end
            end
            carPkg::STOP:
                if (timer.resumeGo) nextState = resumeTarget;
            carPkg::ERROR:
                if (!runEnable) nextState = carPkg::IDLE;
            default: nextState = carPkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= carPkg::IDLE;
            resumeTarget <= carPkg::IDLE;
        end else if (!runEnable) begin
            state <= carPkg::IDLE;
            resumeTarget <= carPkg::IDLE;
        end else begin
            state <= nextState;
            resumeTarget <= resumeNext;
        end
    end

    // a flag is armed by any non-cross sample and dropped once its state is left
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            checkpoint <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (cpRegion[i] && !crossSeen) begin
                    checkpoint[i] <= 1'b1;
                end else if (!cpRegion[i]) begin
                    checkpoint[i] <= 1'b0;
                end
            end
            // straight family starts armed after the countdown
            if (state == carPkg::COUNT && timer.countDone && runEnable) begin
                checkpoint[CP_STRAIGHT] <= 1'b1;
            end
        end
    end

    // counts 111 samples while turning right
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rightCnt <= '0;
        end else if (state != carPkg::RIGHT) begin
            rightCnt <= '0;
        end else if (crossSeen && !rightDone) begin
            rightCnt <= rightCnt + 1'b1;
        end
    end

    always_comb begin
        route.state = state;
        route.resumeTarget = resumeTarget;
        route.checkpointSet = |(checkpoint & cpRegion);
    end

    runLowToIdle: assert property (@(posedge clk) disable iff (rst)
        !runEnable |=> state == carPkg::IDLE)
        else $error("state did not return to IDLE after runEnable went low");

    stopResumeValid: assert property (@(posedge clk) disable iff (rst)
        ((state != carPkg::STOP) ##1 (state == carPkg::STOP)) |-> resumeTarget != carPkg::STOP)
        else $error("STOP entered with STOP as resume target");

endmodule

// File: design/carPkg.sv
package carPkg;

    // route FSM states, values match the motor block modes
    typedef enum logic [4:0] {
        IDLE         = 5'd0,
        START        = 5'd1,
        COUNT        = 5'd2,
        STRAIGHT     = 5'd3,
        CHOOSE       = 5'd4,
        LEFT         = 5'd5,
        RIGHT        = 5'd6,
        BACK         = 5'd7,
        LITTLE_LEFT  = 5'd8,
        LITTLE_RIGHT = 5'd9,
        STOP         = 5'd30,
        ERROR        = 5'd31
    } routeState_t;

    // floor sensor patterns, left sensor in the msb
    typedef enum logic [2:0] {
        ROAD_LOST         = 3'b000,
        LITTLE_RIGHT_ROAD = 3'b001,
        STRAIGHT_ROAD     = 3'b010,
        RIGHT_ROAD        = 3'b011,
        LITTLE_LEFT_ROAD  = 3'b100,
        FORK_ROAD         = 3'b101,
        LEFT_ROAD         = 3'b110,
        CROSS_ROAD        = 3'b111
    } roadPattern_t;

    typedef struct packed {
        logic       countDone;
        logic [1:0] countDigit;
        logic       resumeGo;
        logic       flash;
    } timerStatus_t;

    typedef struct packed {
        routeState_t state;
        routeState_t resumeTarget;
        logic        checkpointSet;
    } routeStatus_t;

    typedef struct packed {
        logic [3:0] digit0;
        logic [3:0] digit1;
        logic [3:0] digit2;
        logic [3:0] digit3;
    } digitCodes_t;

endpackage

// File: include/car_cfg.svh
`ifndef CAR_CFG_SVH
`define CAR_CFG_SVH

// clock cycles per timer tick, scaled down from the board rate
`define CAR_TICK_CYCLES 8

// countdown length in ticks
`define CAR_COUNT_TICKS 3

// stop pause length in ticks
`define CAR_STOP_TICKS 2

// half period of the flashing middle LEDs, in cycles
`define CAR_FLASH_CYCLES 4

// choose lamp rotation period, in cycles
`define CAR_LAMP_CYCLES 6

// 111 samples needed in RIGHT before the turn counts as done
`define CAR_RIGHT_CONFIRM 3

// width of the cycle dividers
`define CAR_DIV_WIDTH 8

// width of the tick counter
`define CAR_TICK_WIDTH 3

`endif
